//--- source/lsu_pkg.sv
// load/store opcodes and the request and response records of the memory stage
package lsu_pkg;

    // byte lanes in one data word
    localparam int LANES = 4;

    // read marker for a lane pattern the memory does not know
    localparam logic [31:0] BAD_LANES_VALUE = 32'hDEADBEEF;

    // opcodes as decoded by the execute stage
    // OP_NONE means no access this cycle
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } lsu_op_e;

    // one enable per byte of the word
    // bit 0 is the lowest addressed byte
    typedef logic [LANES-1:0] lane_en_t;

    // incoming request, 68 bits
    typedef struct packed {
        lsu_op_e     op;
        // byte address
        logic [31:0] addr;
        // store data, right aligned for byte and half-word stores
        logic [31:0] wdata;
    } mem_req_t;

    // result one cycle after the request, 34 bits
    typedef struct packed {
        // extended load data, zero for stores and faults
        logic [31:0] rdata;
        // misaligned or out of range
        logic        fault;
        // a load or store was issued the cycle before
        logic        done;
    } mem_resp_t;

endpackage

//--- source/mem_map_pkg.sv
// address map of the data memory
package mem_map_pkg;

    // 128 KiB of data memory
    localparam int MEM_WORDS = 32768;

    // bytes covered by the array
    localparam int MEM_BYTES = MEM_WORDS * 4;

    // highest valid byte address, 0x0001FFFF
    localparam logic [31:0] TOP_ADDR = 32'(MEM_BYTES - 1);

    // bits needed to index one word
    // 15 for the size above
    localparam int WORD_IDX_W = $clog2(MEM_WORDS);

endpackage

//--- source/lsu_align.sv
`timescale 1ns/1ps

module lsu_align (
    input  lsu_pkg::mem_req_t                  req_i,
    output logic [mem_map_pkg::WORD_IDX_W-1:0] word_idx_o,
    output lsu_pkg::lane_en_t                  lanes_o,
    output logic                               wr_en_o,
    output logic [31:0]                        wr_data_o,
    output logic                               is_load_o,
    output logic                               fault_o
);
    import lsu_pkg::*;
    import mem_map_pkg::*;

    // access size from the opcode
    logic        size_byte;
    logic        size_half;
    logic        size_word;
    logic        is_store;
    logic        access;
    // byte position inside the word
    logic [1:0]  offset;
    logic        misaligned;
    logic        out_of_range;
    // lanes and data before the offset shift
    lane_en_t    base_lanes;
    logic [31:0] base_data;

    assign offset = req_i.addr[1:0];

    // opcode decode
    always_comb begin
        size_byte = 1'b0;
        size_half = 1'b0;
        size_word = 1'b0;
        is_load_o = 1'b0;
        is_store  = 1'b0;
        case (req_i.op)
            OP_LB, OP_LBU: begin
                size_byte = 1'b1;
                is_load_o = 1'b1;
            end
            OP_LH, OP_LHU: begin
                size_half = 1'b1;
                is_load_o = 1'b1;
            end
            OP_LW: begin
                size_word = 1'b1;
                is_load_o = 1'b1;
            end
            OP_SB: begin
                size_byte = 1'b1;
                is_store  = 1'b1;
            end
            OP_SH: begin
                size_half = 1'b1;
                is_store  = 1'b1;
            end
            OP_SW: begin
                size_word = 1'b1;
                is_store  = 1'b1;
            end
            // OP_NONE and unused codes make no access
            default: begin
                is_store = 1'b0;
            end
        endcase
    end

    assign access = is_load_o | is_store;

    // half-words need an even address, words a multiple of 4
    assign misaligned = (size_half & offset[0]) | (size_word & (offset != 2'b00));
    // anything past the last byte of the array
    assign out_of_range = req_i.addr > TOP_ADDR;
    assign fault_o = access & (misaligned | out_of_range);

    // lane mask and data at the bottom of the word
    always_comb begin
        base_lanes = '0;
        base_data  = '0;
        if (size_byte) begin
            base_lanes = 4'b0001;
            base_data  = {24'b0, req_i.wdata[7:0]};
        end else if (size_half) begin
            base_lanes = 4'b0011;
            base_data  = {16'b0, req_i.wdata[15:0]};
        end else if (size_word) begin
            base_lanes = 4'b1111;
            base_data  = req_i.wdata;
        end
    end

    // move lanes and data up to the addressed byte
    // a faulted access touches no lane
    assign lanes_o   = fault_o ? '0 : lane_en_t'(base_lanes << offset);
    assign wr_data_o = base_data << {offset, 3'b000};
    assign wr_en_o   = is_store & ~fault_o;

    // word index drops the byte offset
    assign word_idx_o = req_i.addr[WORD_IDX_W+1:2];

endmodule

//--- source/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                               clk,
    input  lsu_pkg::lane_en_t                  lanes_i,
    input  logic                               wr_en_i,
    input  logic [mem_map_pkg::WORD_IDX_W-1:0] word_idx_i,
    input  logic [31:0]                        wr_data_i,
    output logic [31:0]                        rd_data_o
);
    import lsu_pkg::*;
    import mem_map_pkg::*;

    // word array, contents undefined until written
    logic [31:0] mem [MEM_WORDS];

    // lane pattern is one byte, one aligned half-word or the full word
    logic lanes_ok;

    always_comb begin
        case (lanes_i)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: lanes_ok = 1'b1;
            4'b0011, 4'b1100:                   lanes_ok = 1'b1;
            4'b1111:                            lanes_ok = 1'b1;
            default:                            lanes_ok = 1'b0;
        endcase
    end

    // per-lane write
    // other bytes of the word keep their value
    always_ff @(posedge clk) begin
        if (wr_en_i && lanes_ok) begin
            for (int i = 0; i < LANES; i++) begin
                if (lanes_i[i]) begin
                    mem[word_idx_i][8*i +: 8] <= wr_data_i[8*i +: 8];
                end
            end
        end
    end

    // registered read of the whole word
    // same-cycle write shows up on the next read only
    always_ff @(posedge clk) begin
        if (lanes_i == '0) begin
            // no access
            rd_data_o <= '0;
        end else if (lanes_ok) begin
            rd_data_o <= mem[word_idx_i];
        end else begin
            // marker for an unknown lane pattern
            rd_data_o <= BAD_LANES_VALUE;
        end
    end

endmodule

//--- source/load_extend.sv
`timescale 1ns/1ps

module load_extend (
    input  logic               clk,
    input  logic               reset_i,
    input  lsu_pkg::lsu_op_e   op_i,
    input  logic [1:0]         offset_i,
    input  logic               is_load_i,
    input  logic               fault_i,
    input  logic [31:0]        rd_word_i,
    output lsu_pkg::mem_resp_t resp_o
);
    import lsu_pkg::*;

    // request context held for the read cycle
    lsu_op_e     op_q;
    logic [1:0]  off_q;
    logic        access_q;
    logic        load_q;
    logic        fault_q;
    // read word with the addressed byte at bit 0
    logic [31:0] shifted;
    // extended value before the load and fault gating
    logic [31:0] load_data;

    // control context
    always_ff @(posedge clk) begin
        if (reset_i) begin
            op_q     <= OP_NONE;
            access_q <= 1'b0;
            load_q   <= 1'b0;
            fault_q  <= 1'b0;
        end else begin
            op_q     <= op_i;
            access_q <= (op_i != OP_NONE);
            load_q   <= is_load_i;
            fault_q  <= fault_i;
        end
    end

    // byte offset only steers the select
    always_ff @(posedge clk) begin
        off_q <= offset_i;
    end

    assign shifted = rd_word_i >> {off_q, 3'b000};

    // sign or zero extension by opcode
    always_comb begin
        case (op_q)
            OP_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            OP_LBU:  load_data = {24'b0, shifted[7:0]};
            OP_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            OP_LHU:  load_data = {16'b0, shifted[15:0]};
            OP_LW:   load_data = rd_word_i;
            // stores and no access
            default: load_data = '0;
        endcase
    end

    // response for the request of the previous cycle
    always_comb begin
        resp_o.done  = access_q;
        resp_o.fault = fault_q;
        // faulted loads and stores return zero
        resp_o.rdata = (load_q && !fault_q) ? load_data : '0;
    end

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  lsu_pkg::mem_req_t  req_i,
    output lsu_pkg::mem_resp_t resp_o
);
    import lsu_pkg::*;
    import mem_map_pkg::*;

    // align to memory
    logic [WORD_IDX_W-1:0] word_idx;
    lane_en_t              lanes;
    logic                  wr_en;
    logic [31:0]           wr_data;
    // align to extend
    logic                  is_load;
    logic                  fault;
    // memory to extend
    logic [31:0]           rd_word;

    // request decode, combinational
    lsu_align i_lsu_align (
        .req_i      (req_i),
        .word_idx_o (word_idx),
        .lanes_o    (lanes),
        .wr_en_o    (wr_en),
        .wr_data_o  (wr_data),
        .is_load_o  (is_load),
        .fault_o    (fault)
    );

    // storage with one cycle read
    data_mem i_data_mem (
        .clk        (clk),
        .lanes_i    (lanes),
        .wr_en_i    (wr_en),
        .word_idx_i (word_idx),
        .wr_data_i  (wr_data),
        .rd_data_o  (rd_word)
    );

    // opcode and offset come straight from the request
    load_extend i_load_extend (
        .clk       (clk),
        .reset_i   (reset_i),
        .op_i      (req_i.op),
        .offset_i  (req_i.addr[1:0]),
        .is_load_i (is_load),
        .fault_i   (fault),
        .rd_word_i (rd_word),
        .resp_o    (resp_o)
    );

endmodule

//--- dv/mem_stage_assert.sv
`timescale 1ns/1ps

module mem_stage_assert (
    input logic               clk,
    input logic               reset_i,
    input lsu_pkg::lsu_op_e   op_q_i,
    input lsu_pkg::mem_resp_t resp_i
);
    import lsu_pkg::*;

    // context registers are clear one cycle after reset
    done_after_reset: assert property (@(posedge clk) reset_i |=> !resp_i.done)
        else $error("done high in the cycle after reset");

    // faulted access never returns data
    fault_zero_data: assert property (@(posedge clk) disable iff (reset_i)
        resp_i.fault |-> (resp_i.rdata == '0))
        else $error("fault raised with nonzero rdata");

    // stores answer with done and zero data
    store_no_data: assert property (@(posedge clk) disable iff (reset_i)
        (resp_i.done && (op_q_i inside {OP_SB, OP_SH, OP_SW})) |-> (resp_i.rdata == '0))
        else $error("store returned nonzero rdata");

endmodule

// attached to the response side of the stage
bind load_extend mem_stage_assert i_mem_stage_assert (
    .clk     (clk),
    .reset_i (reset_i),
    .op_q_i  (op_q),
    .resp_i  (resp_o)
);

//--- dv/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;
    import lsu_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DELAY  = 10;
    localparam int    RESET_CYCLES = 3;
    localparam string GOLDEN_FILE  = "dv/mem_stage_golden.txt";

    logic      clk;
    logic      reset_i;
    mem_req_t  req;
    mem_resp_t resp;

    // golden requests, one entry per data line
    lsu_op_e     ops[$];
    logic [31:0] addrs[$];
    logic [31:0] wdatas[$];
    logic [31:0] exp_datas[$];
    logic        exp_faults[$];
    // test group of each request
    int          grp_of[$];
    string       grp_names[$];

    bit golden_ready = 1'b0;
    int check_count;
    int error_count;
    int group_reqs;
    int group_errs;
    int groups_passed;
    int groups_failed;

    mem_stage i_mem_stage (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (req),
        .resp_o  (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // mnemonic in the golden file to opcode, via the enum names
    function automatic lsu_op_e op_from_name(input string name, output bit known);
        lsu_op_e op;
        op = op.first();
        known = 1'b0;
        for (int i = 0; i < op.num(); i++) begin
            if (op.name() == {"OP_", name}) begin
                known = 1'b1;
                break;
            end
            op = op.next();
        end
        return op;
    endfunction

    // whole golden file into the queues
    task automatic load_golden(output bit ok);
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        string       token;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] fault;
        lsu_op_e     op;
        bit          known;
        ok = 1'b1;
        line_no = 0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("golden file %s could not be opened", GOLDEN_FILE);
            ok = 1'b0;
        end else begin
            while (ok && $fgets(line, fd) != 0) begin
                line_no++;
                fields = $sscanf(line, "%s", token);
                // blank lines and comments carry nothing
                if (fields < 1 || token.getc(0) == "#") begin
                    fields = 0;
                end else if (token.getc(0) == "@") begin
                    grp_names.push_back(token.substr(1, token.len() - 1));
                end else begin
                    fields = $sscanf(line, "%s %h %h %h %h", token, addr, wdata, rdata, fault);
                    op = op_from_name(token, known);
                    if (fields != 5) begin
                        $display("golden line %0d is short, it has %0d of 5 fields",
                                 line_no, fields);
                        ok = 1'b0;
                    end else if (!known) begin
                        $display("golden line %0d names unknown opcode %s", line_no, token);
                        ok = 1'b0;
                    end else begin
                        if (grp_names.size() == 0) begin
                            grp_names.push_back("ungrouped");
                        end
                        ops.push_back(op);
                        addrs.push_back(addr);
                        wdatas.push_back(wdata);
                        exp_datas.push_back(rdata);
                        exp_faults.push_back(fault[0]);
                        grp_of.push_back(grp_names.size() - 1);
                    end
                end
            end
            $fclose(fd);
            if (ok && ops.size() == 0) begin
                $display("golden file %s holds no requests", GOLDEN_FILE);
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_resp_data(input mem_resp_t got, input logic [31:0] exp, input int idx);
        lsu_op_e op;
        op = ops[idx];
        check_count++;
        if (got.rdata !== exp) begin
            error_count++;
            $display("[ERROR] %0d ns: request %0d %s at %h gave rdata %h, expected %h",
                     $time, idx, op.name(), addrs[idx], got.rdata, exp);
        end
    endtask

    task automatic check_resp_flags(input mem_resp_t got, input logic exp_fault,
                                    input logic exp_done, input int idx);
        lsu_op_e op;
        op = ops[idx];
        check_count++;
        if (got.fault !== exp_fault || got.done !== exp_done) begin
            error_count++;
            $display("[ERROR] %0d ns: request %0d %s at %h gave fault/done %b/%b, expected %b/%b",
                     $time, idx, op.name(), addrs[idx], got.fault, got.done,
                     exp_fault, exp_done);
        end
    endtask

    // response of request j, then the group line when its group ends
    task automatic check_entry(input int j);
        logic exp_done;
        int   errs_before;
        errs_before = error_count;
        // done follows from the opcode alone
        exp_done = (ops[j] != OP_NONE);
        check_resp_data(resp, exp_datas[j], j);
        check_resp_flags(resp, exp_faults[j], exp_done, j);
        group_reqs++;
        if (error_count != errs_before) begin
            group_errs++;
        end
        if (j == ops.size() - 1 || grp_of[j + 1] != grp_of[j]) begin
            $display("test %-18s %0d requests, %0d failing", grp_names[grp_of[j]],
                     group_reqs, group_errs);
            if (group_errs == 0) begin
                groups_passed++;
            end else begin
                groups_failed++;
            end
            group_reqs = 0;
            group_errs = 0;
        end
    endtask

    // one request per cycle, each checked one cycle after it is sampled
    task automatic run_requests();
        int n;
        n = ops.size();
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (i > 0) begin
                check_entry(i - 1);
            end
            if (i < n) begin
                req.op    = ops[i];
                req.addr  = addrs[i];
                req.wdata = wdatas[i];
            end else begin
                req = '0;
            end
        end
    endtask

    initial begin
        bit load_ok;
        reset_i       = 1'b1;
        req           = '0;
        check_count   = 0;
        error_count   = 0;
        group_reqs    = 0;
        group_errs    = 0;
        groups_passed = 0;
        groups_failed = 0;
        load_golden(load_ok);
        if (!load_ok) begin
            $display("*** FAILED ***");
        end else begin
            golden_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #(DRIVE_DELAY);
            reset_i = 1'b0;
            run_requests();
            $display("%0d requests, %0d checks, %0d errors, %0d groups passed, %0d failed",
                     ops.size(), check_count, error_count, groups_passed, groups_failed);
            if (error_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
        end
        $finish;
    end

    // watchdog sized from the request count plus reset and slack
    initial begin
        int limit_ns;
        wait (golden_ready);
        limit_ns = (ops.size() + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog expired after %0d ns before all requests were checked", limit_ns);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- dv/mem_stage_golden.txt
# columns are opcode, byte address, store data, expected rdata and expected fault
# numbers are hex
# a line starting with @ opens a test group
@word_store_load
SW   00000100 12345678 00000000 0
LW   00000100 00000000 12345678 0
SW   0001fffc a5a5a5a5 00000000 0
LW   0001fffc 00000000 a5a5a5a5 0
@byte_half_merge
SW   00000200 11223344 00000000 0
SB   00000201 000000aa 00000000 0
LW   00000200 00000000 1122aa44 0
SB   00000203 000000bb 00000000 0
LW   00000200 00000000 bb22aa44 0
SH   00000202 0000ccdd 00000000 0
LW   00000200 00000000 ccddaa44 0
SH   00000200 12349876 00000000 0
LW   00000200 00000000 ccdd9876 0
@sign_zero_extend
SW   00000300 80f17f8e 00000000 0
LB   00000300 00000000 ffffff8e 0
LBU  00000300 00000000 0000008e 0
LB   00000301 00000000 0000007f 0
LB   00000302 00000000 fffffff1 0
LBU  00000303 00000000 00000080 0
LH   00000300 00000000 00007f8e 0
LH   00000302 00000000 ffff80f1 0
LHU  00000302 00000000 000080f1 0
@misaligned_fault
SW   00000400 0badf00d 00000000 0
LH   00000401 00000000 00000000 1
LW   00000402 00000000 00000000 1
SH   00000403 0000ffff 00000000 1
SW   00000401 ffffffff 00000000 1
SW   00000402 ffffffff 00000000 1
LW   00000400 00000000 0badf00d 0
@out_of_range_fault
SW   00000000 600dcafe 00000000 0
SW   00020000 deadbeef 00000000 1
LB   0003ffff 00000000 00000000 1
SB   80000000 000000ff 00000000 1
LW   00000000 00000000 600dcafe 0
NONE 00000100 12345678 00000000 0
LW   00020000 00000000 00000000 1
@back_to_back
SW   00000500 01020304 00000000 0
LW   00000500 00000000 01020304 0
SB   00000500 000000ff 00000000 0
LW   00000500 00000000 010203ff 0
SH   00000502 0000abcd 00000000 0
LH   00000502 00000000 ffffabcd 0
LW   00000100 00000000 12345678 0
LBU  00000501 00000000 00000003 0

//--- filelist.f
source/lsu_pkg.sv
source/mem_map_pkg.sv
source/lsu_align.sv
source/data_mem.sv
source/load_extend.sv
source/mem_stage.sv
dv/mem_stage_assert.sv
dv/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module mem_stage_tb \
    -o mem_stage_sim

sim_status=0
sim_out=$(./obj_dir/mem_stage_sim) || sim_status=$?
echo "$sim_out"

# pass only when the testbench printed its pass line
if [ "$sim_status" -eq 0 ] && echo "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
